// ==== list.f ====
verilog/obi_pkg.sv
verilog/mcu_pkg.sv
verilog/system_bus.sv
verilog/memory_subsystem.sv
verilog/peripheral_subsystem.sv
verilog/mini_mcu.sv
tests/tb_mini_mcu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mini MCU testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tb_mini_mcu -f list.f -o sim_mini_mcu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_mini_mcu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^RESULT: PASS$" "$LOG"
if [ $? -ne 0 ]; then
  echo "pass message not found in $LOG"
  exit 1
fi

exit 0

// ==== tests/bus_input.txt ====
# id mode(0 m0,1 m1,2 both,3 m0 back-to-back) we be addr wdata | we1 be1 addr1 wdata1
# exp_rdata exp_err exp_rdata1 exp_err1 gpio_i exp_pin (gpio_o or exit value)
1 0 1 f 00000000 11223344 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
2 0 0 f 00000000 00000000 0 0 00000000 00000000 11223344 0 00000000 0 00000000 00000000
3 1 1 f 00000400 aabbccdd 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
4 1 0 f 00000400 00000000 0 0 00000000 00000000 aabbccdd 0 00000000 0 00000000 00000000
5 0 1 3 00000400 00005566 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
6 1 0 f 00000400 00000000 0 0 00000000 00000000 aabb5566 0 00000000 0 00000000 00000000
7 1 1 f 00000004 01020304 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
8 1 1 c 00000004 9999ffff 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
9 0 0 f 00000004 00000000 0 0 00000000 00000000 99990304 0 00000000 0 00000000 00000000
10 0 1 f 000007fc 0badf00d 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
11 0 1 1 000007fc 000000ee 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
12 1 0 f 000007fc 00000000 0 0 00000000 00000000 0badf0ee 0 00000000 0 00000000 00000000
13 2 1 f 00000008 cafef00d 1 f 00000408 12345678 00000000 0 00000000 0 00000000 00000000
14 2 0 f 00000408 00000000 0 f 00000008 00000000 12345678 0 cafef00d 0 00000000 00000000
15 0 1 f 20000000 12345678 0 0 00000000 00000000 00000000 0 00000000 0 00000000 12345678
16 1 1 2 20000000 0000ab00 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
17 0 0 f 20000000 00000000 0 0 00000000 00000000 1234ab78 0 00000000 0 00000000 00000000
18 1 0 f 20000004 00000000 0 0 00000000 00000000 5a5a0ff0 0 00000000 0 5a5a0ff0 00000000
19 0 1 f 20000004 ffffffff 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
20 0 1 f 20000008 000000aa 0 0 00000000 00000000 00000000 0 00000000 0 00000000 000000aa
21 1 1 f 20000008 deadbeef 0 0 00000000 00000000 00000000 0 00000000 0 00000000 00000000
22 0 0 f 20000008 00000000 0 0 00000000 00000000 deadbeef 0 00000000 0 00000000 00000000
23 0 0 f 20000010 00000000 0 0 00000000 00000000 00000000 1 00000000 0 00000000 00000000
24 1 1 f 200000fc 11111111 0 0 00000000 00000000 00000000 1 00000000 0 00000000 00000000
25 0 0 f 00000800 00000000 0 0 00000000 00000000 00000000 1 00000000 0 00000000 00000000
26 1 0 f 40000000 00000000 0 0 00000000 00000000 00000000 1 00000000 0 00000000 00000000
27 0 1 f 1ffffffc 22222222 0 0 00000000 00000000 00000000 1 00000000 0 00000000 00000000
28 3 1 f 0000000c 13572468 0 f 0000000c 00000000 00000000 0 13572468 0 00000000 00000000
29 3 0 f 00000000 00000000 0 f 00000400 00000000 11223344 0 aabb5566 0 00000000 00000000
30 3 0 f 50000000 00000000 0 f 00000004 00000000 00000000 1 99990304 0 00000000 00000000
31 2 0 f 20000004 00000000 0 f 000007fc 00000000 0f0f0f0f 0 0badf0ee 0 0f0f0f0f 00000000
32 2 0 f 20000020 00000000 0 f 0000000c 00000000 00000000 1 13572468 0 00000000 00000000

// ==== tests/tb_mini_mcu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for the mini MCU, replays
// tests/bus_input.txt on both OBI master ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_mini_mcu
  import obi_pkg::*;
  import mcu_pkg::*;
;

  // one line of the stimulus file
  typedef struct packed {
    logic [31:0] id;
    logic [31:0] mode;
    logic [31:0] we0, be0, addr0, wdata0;
    logic [31:0] we1, be1, addr1, wdata1;
    logic [31:0] rdata0, err0, rdata1, err1;
    logic [31:0] gpio, pin;
  } op_t;

  logic                        clk_i;
  logic                        rst_i;
  obi_req_t  [NUM_MASTERS-1:0] master_req;
  obi_resp_t [NUM_MASTERS-1:0] master_resp;
  logic [31:0]                 gpio_i;
  logic [31:0]                 gpio_o;
  logic [31:0]                 exit_value_o;
  logic                        exit_valid_o;

  op_t         ops[$];
  logic        loaded;
  int          cur_test;
  int          test_errs;
  logic [31:0] lfsr;

  mini_mcu u_mini_mcu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .master_req_i  (master_req),
    .master_resp_o (master_resp),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two bits, one step each
  task automatic idle_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      gap  = gap | (int'(lfsr[0]) << i);
    end
    repeat (gap) @(posedge clk_i);
  endtask

  task automatic report_value(input string sig, input logic [31:0] got, exp);
    $display("FAIL test %0d %s got %h expected %h", cur_test, sig, got, exp);
    test_errs++;
  endtask

  task automatic report_text(input string what);
    $display("error in test %0d: %s", cur_test, what);
    test_errs++;
  endtask

  task automatic drive_req(input int m, input logic [31:0] we, be, addr, wdata);
    master_req[m].req   = 1'b1;
    master_req[m].we    = we[0];
    master_req[m].be    = be[3:0];
    master_req[m].addr  = addr;
    master_req[m].wdata = wdata;
  endtask

  // counts negedges until gnt is seen
  task automatic wait_grant(input int m, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!master_resp[m].gnt && cycles < 10);
    if (!master_resp[m].gnt) report_text($sformatf("master %0d never granted", m));
  endtask

  // sampled at the negedge after the grant edge
  task automatic check_resp(input int m, input logic [31:0] we, exp_rdata, exp_err);
    if (!master_resp[m].rvalid) begin
      report_text($sformatf("master %0d got no response in the cycle after grant", m));
    end else begin
      if (master_resp[m].err != exp_err[0])
        report_value($sformatf("err%0d", m), 32'(master_resp[m].err), exp_err);
      if ((!we[0] || exp_err[0]) && master_resp[m].rdata != exp_rdata)
        report_value($sformatf("rdata%0d", m), master_resp[m].rdata, exp_rdata);
    end
  endtask

  task automatic single_op(input int m, input logic [31:0] we, be, addr, wdata,
                           input logic [31:0] exp_rdata, exp_err, output int cycles);
    @(posedge clk_i);
    #1 drive_req(m, we, be, addr, wdata);
    wait_grant(m, cycles);
    @(posedge clk_i);
    #1 master_req[m].req = 1'b0;
    @(negedge clk_i);
    check_resp(m, we, exp_rdata, exp_err);
  endtask

  task automatic check_pins(input op_t op);
    if (op.we0[0] && op.addr0 == PERIPH_START_ADDRESS + 32'(GPIO_OUT_OFFSET)) begin
      if (gpio_o != op.pin) report_value("gpio_o", gpio_o, op.pin);
    end
    if (op.we0[0] && op.addr0 == PERIPH_START_ADDRESS + 32'(EXIT_VALUE_OFFSET)) begin
      if (exit_value_o != op.pin) report_value("exit_value_o", exit_value_o, op.pin);
      if (!exit_valid_o) report_text("exit_valid_o not raised after the grant");
      @(negedge clk_i);
      if (exit_valid_o) report_text("exit_valid_o held longer than one cycle");
    end
  endtask

  task automatic run_op(input op_t op);
    int c0;
    int c1;
    @(posedge clk_i);
    #1 gpio_i = op.gpio;
    case (op.mode)
      0, 1: begin
        single_op(int'(op.mode), op.we0, op.be0, op.addr0, op.wdata0, op.rdata0, op.err0, c0);
        // pin column only filled for master 0 writes
        if (op.mode == 0) check_pins(op);
      end
      2: begin
        fork
          single_op(0, op.we0, op.be0, op.addr0, op.wdata0, op.rdata0, op.err0, c0);
          single_op(1, op.we1, op.be1, op.addr1, op.wdata1, op.rdata1, op.err1, c1);
        join
        if (c0 != 1) report_text("master 0 not granted first");
        if (c1 < 2) report_text("master 1 granted while master 0 was requesting");
      end
      default: begin
        // second request issued right after the first grant
        @(posedge clk_i);
        #1 drive_req(0, op.we0, op.be0, op.addr0, op.wdata0);
        wait_grant(0, c0);
        @(posedge clk_i);
        #1 drive_req(0, op.we1, op.be1, op.addr1, op.wdata1);
        @(negedge clk_i);
        check_resp(0, op.we0, op.rdata0, op.err0);
        if (!master_resp[0].gnt) report_text("back-to-back request not granted");
        @(posedge clk_i);
        #1 master_req[0].req = 1'b0;
        @(negedge clk_i);
        check_resp(0, op.we1, op.rdata1, op.err1);
      end
    endcase
  endtask

  task automatic load_ops();
    int    fd;
    int    n;
    string line;
    op_t   op;
    fd = $fopen("tests/bus_input.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 8 || line[0] == "#") continue;
      n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  op.id, op.mode, op.we0, op.be0, op.addr0, op.wdata0,
                  op.we1, op.be1, op.addr1, op.wdata1,
                  op.rdata0, op.err0, op.rdata1, op.err1, op.gpio, op.pin);
      if (n == 16) ops.push_back(op);
    end
    $fclose(fd);
  endtask

  initial begin
    wait (loaded);
    repeat (ops.size() * 20 + 200) @(posedge clk_i);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int passed;
    int failed;
    rst_i      = 1'b1;
    master_req = '0;
    gpio_i     = '0;
    loaded     = 1'b0;
    passed     = 0;
    failed     = 0;
    lfsr       = 32'hcc895f19;
    load_ops();
    if (ops.size() == 0) begin
      $display("no operations read from tests/bus_input.txt");
      failed = 1;
    end
    loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    #1 rst_i = 1'b0;
    foreach (ops[i]) begin
      cur_test  = int'(ops[i].id);
      test_errs = 0;
      run_op(ops[i]);
      if (test_errs == 0) begin
        $display("test %0d ok", cur_test);
        passed++;
      end else begin
        $display("test %0d failed with %0d errors", cur_test, test_errs);
        failed++;
      end
      idle_gap();
    end
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/mcu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory map, bank layout and peripheral register
// offsets of the mini MCU
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mcu_pkg;

  // bus masters on the system bus
  localparam int NUM_MASTERS = 2;

  // ram layout, bank select is the bit above the bank offset
  localparam int NUM_BANKS = 2;
  localparam int BANK_SIZE = 1024;
  localparam int MEM_SIZE  = NUM_BANKS * BANK_SIZE;

  localparam logic [31:0] RAM_START_ADDRESS    = 32'h0000_0000;
  localparam logic [31:0] PERIPH_START_ADDRESS = 32'h2000_0000;
  localparam int          PERIPH_SIZE          = 256;

  // byte offsets inside the peripheral block
  localparam logic [7:0] GPIO_OUT_OFFSET   = 8'h00;
  localparam logic [7:0] GPIO_IN_OFFSET    = 8'h04;
  localparam logic [7:0] EXIT_VALUE_OFFSET = 8'h08;

endpackage

// ==== verilog/memory_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked word SRAM behind the system bus, one OBI
// port per bank, read data one cycle after grant
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module memory_subsystem
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic                       clk_i,

  input  obi_req_t  [NUM_BANKS-1:0]  ram_req_i,
  output obi_resp_t [NUM_BANKS-1:0]  ram_resp_o
);

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank

    logic [31:0]                  mem_q [BANK_SIZE/4];
    logic [$clog2(BANK_SIZE)-3:0] word_idx;
    logic [31:0]                  rdata_q;
    logic                         rvalid_q;

    // byte offset bits dropped, bank bit handled by the bus
    assign word_idx = ram_req_i[b].addr[$clog2(BANK_SIZE)-1:2];

    always_ff @(posedge clk_i) begin
      if (ram_req_i[b].req && ram_req_i[b].we) begin
        for (int i = 0; i < 4; i++) begin
          if (ram_req_i[b].be[i]) begin
            mem_q[word_idx][i*8 +: 8] <= ram_req_i[b].wdata[i*8 +: 8];
          end
        end
      end
    end

    // writes answer with zero data
    always_ff @(posedge clk_i) begin
      rvalid_q <= ram_req_i[b].req;
      if (ram_req_i[b].req) begin
        rdata_q <= ram_req_i[b].we ? '0 : mem_q[word_idx];
      end
    end

    // never stalls
    assign ram_resp_o[b] = '{
      gnt:    ram_req_i[b].req,
      rvalid: rvalid_q,
      err:    1'b0,
      rdata:  rdata_q
    };

  end

endmodule

// ==== verilog/mini_mcu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini MCU top: external masters on the system bus,
// banked ram and the peripheral block behind it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mini_mcu
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  obi_req_t  [NUM_MASTERS-1:0]  master_req_i,
  output obi_resp_t [NUM_MASTERS-1:0]  master_resp_o,

  input  logic [31:0]                  gpio_i,
  output logic [31:0]                  gpio_o,

  output logic [31:0]                  exit_value_o,
  output logic                         exit_valid_o
);

  // ram banks
  obi_req_t  [NUM_BANKS-1:0] ram_slave_req;
  obi_resp_t [NUM_BANKS-1:0] ram_slave_resp;

  // peripheral block
  obi_req_t  periph_slave_req;
  obi_resp_t periph_slave_resp;

  system_bus u_system_bus (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .master_req_i  (master_req_i),
    .master_resp_o (master_resp_o),
    .ram_req_o     (ram_slave_req),
    .ram_resp_i    (ram_slave_resp),
    .periph_req_o  (periph_slave_req),
    .periph_resp_i (periph_slave_resp)
  );

  memory_subsystem u_memory_subsystem (
    .clk_i      (clk_i),
    .ram_req_i  (ram_slave_req),
    .ram_resp_o (ram_slave_resp)
  );

  peripheral_subsystem u_peripheral_subsystem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slave_req_i  (periph_slave_req),
    .slave_resp_o (periph_slave_resp),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

// ==== verilog/obi_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OBI request/response and register-interface structs,
// imported by every block that touches the bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package obi_pkg;

  // master to slave, held stable until gnt
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  // gnt in the request cycle, rvalid one cycle later
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  // register access inside the peripheral block
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

// ==== verilog/peripheral_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripheral block: OBI to register bridge with the
// GPIO output, GPIO input and exit registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module peripheral_subsystem
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  input  obi_req_t    slave_req_i,
  output obi_resp_t   slave_resp_o,

  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  logic [31:0] offset;
  logic [31:0] gpio_out_q;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // offset inside the peripheral window
  assign offset = slave_req_i.addr - PERIPH_START_ADDRESS;

  always_comb begin
    reg_req.valid = slave_req_i.req;
    reg_req.write = slave_req_i.we;
    reg_req.addr  = offset[7:0];
    reg_req.wdata = slave_req_i.wdata;
    reg_req.wstrb = slave_req_i.be;
  end

  // read mux and offset check
  always_comb begin
    reg_rsp = '0;
    case (reg_req.addr)
      GPIO_OUT_OFFSET: begin
        if (!reg_req.write) reg_rsp.rdata = gpio_out_q;
      end
      GPIO_IN_OFFSET: begin
        // read only, writes dropped silently
        if (!reg_req.write) reg_rsp.rdata = gpio_i;
      end
      EXIT_VALUE_OFFSET: begin
        if (!reg_req.write) reg_rsp.rdata = exit_value_q;
      end
      default: reg_rsp.error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_q   <= '0;
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q     <= reg_req.valid;
      exit_valid_q <= 1'b0;
      if (reg_req.valid && reg_req.write) begin
        case (reg_req.addr)
          GPIO_OUT_OFFSET: begin
            for (int i = 0; i < 4; i++) begin
              if (reg_req.wstrb[i]) gpio_out_q[i*8 +: 8] <= reg_req.wdata[i*8 +: 8];
            end
          end
          EXIT_VALUE_OFFSET: begin
            exit_value_q <= reg_req.wdata;
            exit_valid_q <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // response payload, qualified by rvalid
  always_ff @(posedge clk_i) begin
    if (reg_req.valid) begin
      rdata_q <= reg_rsp.rdata;
      err_q   <= reg_rsp.error;
    end
  end

  assign slave_resp_o = '{
    gnt:    slave_req_i.req,
    rvalid: rvalid_q,
    err:    err_q,
    rdata:  rdata_q
  };

  assign gpio_o       = gpio_out_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

// ==== verilog/system_bus.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-priority OBI crossbar from the bus masters to
// the ram banks and the peripheral block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module system_bus
  import obi_pkg::*;
  import mcu_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  obi_req_t  [NUM_MASTERS-1:0]  master_req_i,
  output obi_resp_t [NUM_MASTERS-1:0]  master_resp_o,

  output obi_req_t  [NUM_BANKS-1:0]    ram_req_o,
  input  obi_resp_t [NUM_BANKS-1:0]    ram_resp_i,

  output obi_req_t                     periph_req_o,
  input  obi_resp_t                    periph_resp_i
);

  typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;
  typedef logic [$clog2(NUM_BANKS)-1:0]   bank_idx_t;

  // who was granted and where the access went
  typedef struct packed {
    logic        valid;
    master_idx_t master;
    logic        ram;
    logic        periph;
    bank_idx_t   bank;
  } route_t;

  logic        sel_valid;
  master_idx_t sel_master;
  obi_req_t    sel_req;
  logic [31:0] ram_off;
  logic [31:0] periph_off;
  logic        hit_ram;
  logic        hit_periph;
  bank_idx_t   hit_bank;
  logic        sel_gnt;
  route_t      route_d;
  route_t      route_q;
  obi_resp_t   slave_resp;

  // lowest master index wins
  always_comb begin
    sel_valid  = 1'b0;
    sel_master = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (!sel_valid && master_req_i[m].req) begin
        sel_valid  = 1'b1;
        sel_master = master_idx_t'(m);
      end
    end
  end

  assign sel_req = master_req_i[sel_master];

  // unsigned wrap also rejects addresses below each base
  assign ram_off    = sel_req.addr - RAM_START_ADDRESS;
  assign periph_off = sel_req.addr - PERIPH_START_ADDRESS;
  assign hit_ram    = sel_valid && (ram_off < MEM_SIZE);
  assign hit_periph = sel_valid && (periph_off < PERIPH_SIZE);
  assign hit_bank   = ram_off[$clog2(BANK_SIZE) +: $clog2(NUM_BANKS)];

  // payload goes everywhere, only req is steered
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      ram_req_o[b]     = sel_req;
      ram_req_o[b].req = hit_ram && (hit_bank == bank_idx_t'(b));
    end
    periph_req_o     = sel_req;
    periph_req_o.req = hit_periph;
  end

  // unmapped accesses are granted here and answered with err
  always_comb begin
    if (hit_ram) begin
      sel_gnt = ram_resp_i[hit_bank].gnt;
    end else if (hit_periph) begin
      sel_gnt = periph_resp_i.gnt;
    end else begin
      sel_gnt = sel_valid;
    end
  end

  always_comb begin
    route_d.valid  = sel_gnt;
    route_d.master = sel_master;
    route_d.ram    = hit_ram;
    route_d.periph = hit_periph;
    route_d.bank   = hit_bank;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      route_q <= '0;
    end else begin
      route_q <= route_d;
    end
  end

  // response of the slave granted last cycle
  always_comb begin
    if (route_q.ram) begin
      slave_resp = ram_resp_i[route_q.bank];
    end else if (route_q.periph) begin
      slave_resp = periph_resp_i;
    end else begin
      slave_resp        = '0;
      slave_resp.rvalid = 1'b1;
      slave_resp.err    = 1'b1;
    end
  end

  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      master_resp_o[m].gnt    = sel_gnt && (sel_master == master_idx_t'(m));
      master_resp_o[m].rvalid = route_q.valid && slave_resp.rvalid &&
                                (route_q.master == master_idx_t'(m));
      master_resp_o[m].err    = slave_resp.err;
      master_resp_o[m].rdata  = slave_resp.rdata;
    end
  end

endmodule
